// File: build.f
hw/lcd_pkg.sv
hw/lcd_nybble_sender.sv
hw/lcd_byte_sender.sv
hw/lcd_init_sequencer.sv
hw/lcd_controller.sv
verification/lcd_timing_chk.sv
verification/lcd_controller_tb.sv

// File: hw/lcd_byte_sender.sv
// ********************************************************************
// sends a command or character byte as two nybbles, upper first, then
// stays busy for the instruction execution time of that byte
// ********************************************************************
`timescale 1ns/100ps

module lcd_byte_sender (
    input  logic               CLK_I,
    input  logic               RST_I,
    input  logic               i_stb,
    input  logic               i_rs,
    input  logic               i_nybble_only,
    input  lcd_pkg::lcd_byte_t i_data,
    output logic               o_busy,
    output logic               o_rs,
    output logic               o_e,
    output lcd_pkg::nybble_t   o_lcd_data
);
    import lcd_pkg::*;

    // ST_HI and ST_LO each wait for the nybble sender to finish its cycle
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HI,
        ST_LO,
        ST_EXEC
    } state_t;

    state_t    state;
    lcd_byte_t data_q;
    logic      rs_q;
    logic      nyb_only_q;
    logic      ns_stb;
    nybble_t   ns_nybble;
    logic      ns_busy;
    delay_t    exec_cnt;
    delay_t    exec_len;
    logic      long_exec;

    // clear display (0x01) and return home (0x02, 0x03) need the long wait
    assign long_exec = !rs_q && (data_q[7:2] == 6'd0) && (data_q[1:0] != 2'd0);

    // the counter runs down to zero, so load one less than the delay
    assign exec_len = long_exec ? delay_t'(DELAY_3MS - 1) : delay_t'(DELAY_53US - 1);

    assign o_busy = (state != ST_IDLE);

    // control state, the strobe to the nybble sender is a single cycle
    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            state    <= ST_IDLE;
            ns_stb   <= 1'b0;
            exec_cnt <= '0;
        end else begin
            ns_stb <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_stb) begin
                        ns_stb <= 1'b1;
                        state  <= ST_HI;
                    end
                end
                ST_HI: begin
                    // ns_busy is still low in the strobe cycle, skip it
                    if (!ns_stb && !ns_busy) begin
                        if (nyb_only_q) begin
                            // init reset nybbles carry their own wait
                            state <= ST_IDLE;
                        end else begin
                            ns_stb <= 1'b1;
                            state  <= ST_LO;
                        end
                    end
                end
                ST_LO: begin
                    if (!ns_stb && !ns_busy) begin
                        exec_cnt <= exec_len;
                        state    <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (exec_cnt == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        exec_cnt <= exec_cnt - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload, the byte is captured in the cycle the request is accepted
    always_ff @(posedge CLK_I) begin
        if (state == ST_IDLE && i_stb) begin
            data_q     <= i_data;
            rs_q       <= i_rs;
            nyb_only_q <= i_nybble_only;
            ns_nybble  <= i_data[7:4];
        end else if (state == ST_HI && !ns_stb && !ns_busy) begin
            ns_nybble <= data_q[3:0];
        end
    end

    lcd_nybble_sender lcd_nybble_sender_i (
        .CLK_I      (CLK_I),
        .RST_I      (RST_I),
        .i_stb      (ns_stb),
        .i_rs       (rs_q),
        .i_nybble   (ns_nybble),
        .o_busy     (ns_busy),
        .o_rs       (o_rs),
        .o_e        (o_e),
        .o_lcd_data (o_lcd_data)
    );

endmodule

// File: hw/lcd_controller.sv
// ********************************************************************
// hd44780 4-bit driver top, host bytes in through a strobe and busy,
// LCD RS, D7..D4 and E out
// ********************************************************************
`timescale 1ns/100ps

module lcd_controller (
    input  logic               CLK_I,
    input  logic               RST_I,
    input  logic               i_stb,
    input  logic               i_rs,
    input  lcd_pkg::lcd_byte_t i_data,
    output logic               o_busy,
    output logic               o_rs,
    output logic               o_e,
    output lcd_pkg::nybble_t   o_lcd_data
);

    // request path from the init sequencer into the byte sender
    logic               seq_stb;
    logic               seq_rs;
    logic               seq_nybble_only;
    lcd_pkg::lcd_byte_t seq_data;
    logic               send_busy;

    // the sequencer owns the byte sender until init is done
    lcd_init_sequencer lcd_init_sequencer_i (
        .CLK_I         (CLK_I),
        .RST_I         (RST_I),
        .i_stb         (i_stb),
        .i_rs          (i_rs),
        .i_data        (i_data),
        .i_send_busy   (send_busy),
        .o_stb         (seq_stb),
        .o_rs          (seq_rs),
        .o_nybble_only (seq_nybble_only),
        .o_busy        (o_busy),
        .o_data        (seq_data)
    );

    // the byte sender and its nybble sender drive the LCD pins
    lcd_byte_sender lcd_byte_sender_i (
        .CLK_I         (CLK_I),
        .RST_I         (RST_I),
        .i_stb         (seq_stb),
        .i_rs          (seq_rs),
        .i_nybble_only (seq_nybble_only),
        .i_data        (seq_data),
        .o_busy        (send_busy),
        .o_rs          (o_rs),
        .o_e           (o_e),
        .o_lcd_data    (o_lcd_data)
    );

endmodule

// File: hw/lcd_init_sequencer.sv
// ********************************************************************
// runs the hd44780 power-on init from the table after reset, then
// hands the byte sender over to the host
// ********************************************************************
`timescale 1ns/100ps

module lcd_init_sequencer (
    input  logic               CLK_I,
    input  logic               RST_I,
    input  logic               i_stb,
    input  logic               i_rs,
    input  lcd_pkg::lcd_byte_t i_data,
    input  logic               i_send_busy,
    output logic               o_stb,
    output logic               o_rs,
    output logic               o_nybble_only,
    output logic               o_busy,
    output lcd_pkg::lcd_byte_t o_data
);
    import lcd_pkg::*;

    localparam int STEP_BITS = $clog2(INIT_STEPS);
    localparam logic [STEP_BITS-1:0] LAST_STEP = STEP_BITS'(INIT_STEPS - 1);

    // ST_READY is terminal until the next reset
    typedef enum logic [2:0] {
        ST_POWERUP,
        ST_ISSUE,
        ST_SEND,
        ST_DELAY,
        ST_READY
    } state_t;

    state_t                state;
    logic [STEP_BITS-1:0]  step_idx;
    delay_t                delay_cnt;
    logic                  init_stb;
    lcd_byte_t             init_data;
    logic                  init_nyb_only;
    delay_t                step_wait;
    logic                  ready;

    assign ready = (state == ST_READY);

    // once ready the host talks straight to the byte sender
    assign o_stb         = ready ? i_stb : init_stb;
    // every init step is an instruction, so RS stays low until ready
    assign o_rs          = ready ? i_rs : 1'b0;
    assign o_data        = ready ? i_data : init_data;
    assign o_nybble_only = ready ? 1'b0 : init_nyb_only;
    assign o_busy        = !ready || i_send_busy;

    // ****************************************************************
    // step walker
    // ****************************************************************

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            // the power-up wait starts counting straight out of reset
            state     <= ST_POWERUP;
            step_idx  <= '0;
            delay_cnt <= delay_t'(DELAY_100MS - 1);
            init_stb  <= 1'b0;
        end else begin
            init_stb <= 1'b0;
            case (state)
                ST_POWERUP: begin
                    if (delay_cnt == '0) begin
                        state <= ST_ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                ST_ISSUE: begin
                    // the table entry is registered in the same cycle
                    init_stb <= 1'b1;
                    state    <= ST_SEND;
                end
                ST_SEND: begin
                    // byte sender busy only rises the cycle after the strobe
                    if (!init_stb && !i_send_busy) begin
                        delay_cnt <= step_wait;
                        state     <= ST_DELAY;
                    end
                end
                ST_DELAY: begin
                    if (delay_cnt != '0) begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end else if (step_idx == LAST_STEP) begin
                        state <= ST_READY;
                    end else begin
                        step_idx <= step_idx + 1'b1;
                        state    <= ST_ISSUE;
                    end
                end
                default: state <= ST_READY;
            endcase
        end
    end

    // current step's byte, flag and wait, loaded as the step is issued
    always_ff @(posedge CLK_I) begin
        if (state == ST_ISSUE) begin
            init_data     <= INIT_TABLE[step_idx].data;
            init_nyb_only <= INIT_TABLE[step_idx].nybble_only;
            step_wait     <= INIT_TABLE[step_idx].wait_ticks;
        end
    end

endmodule

// File: hw/lcd_nybble_sender.sv
// ********************************************************************
// puts one nybble and RS on the LCD pins and pulses E with the bus
// setup, pulse-width and cycle timing, busy until the cycle is over
// ********************************************************************
`timescale 1ns/100ps

module lcd_nybble_sender (
    input  logic             CLK_I,
    input  logic             RST_I,
    input  logic             i_stb,
    input  logic             i_rs,
    input  lcd_pkg::nybble_t i_nybble,
    output logic             o_busy,
    output logic             o_rs,
    output logic             o_e,
    output lcd_pkg::nybble_t o_lcd_data
);
    import lcd_pkg::*;

    // counter values that bound the E window and the whole cycle
    localparam logic [NYB_COUNT_BITS-1:0] E_RISE = NYB_COUNT_BITS'(TICKS_TAS);
    localparam logic [NYB_COUNT_BITS-1:0] E_FALL = NYB_COUNT_BITS'(TICKS_TAS + TICKS_PWEH);
    localparam logic [NYB_COUNT_BITS-1:0] LAST_TICK = NYB_COUNT_BITS'(TICKS_TCYCE - 1);

    // tick_cnt is zero in the first cycle the new nybble is on the pins
    logic [NYB_COUNT_BITS-1:0] tick_cnt;
    logic [NYB_COUNT_BITS-1:0] tick_next;

    assign tick_next = tick_cnt + 1'b1;

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            o_busy     <= 1'b0;
            o_rs       <= 1'b0;
            o_e        <= 1'b0;
            o_lcd_data <= '0;
            tick_cnt   <= '0;
        end else if (i_stb && !o_busy) begin
            // pins change right away, E follows after the setup time
            o_rs       <= i_rs;
            o_lcd_data <= i_nybble;
            o_busy     <= 1'b1;
            o_e        <= 1'b0;
            tick_cnt   <= '0;
        end else if (o_busy) begin
            tick_cnt <= tick_next;
            // E is registered so it comes out of a flop and cannot glitch
            o_e <= (tick_next >= E_RISE) && (tick_next < E_FALL);
            // the next nybble may start once tcycE has elapsed
            if (tick_cnt == LAST_TICK) begin
                o_busy <= 1'b0;
            end
        end
    end

    // RS and data stay on the pins after busy drops, the LCD only
    // samples them on the falling edge of E

endmodule

// File: hw/lcd_pkg.sv
// ********************************************************************
// shared timing constants, payload types and the power-on init table
// for the hd44780 4-bit driver, imported by each RTL stage
// ********************************************************************

package lcd_pkg;

    // system clock, every delay below is derived from it
    localparam int SYS_FREQ_HZ = 25_000_000;

    // nybble bus timing in clock ticks (40 ns each)
    // tAS is 40 ns minimum, two ticks leave some margin
    localparam int TICKS_TAS   = 2;
    // PWEH must exceed 450 ns
    localparam int TICKS_PWEH  = 12;
    // full enable cycle must be at least 1000 ns
    localparam int TICKS_TCYCE = 25;

    // long delays for init and instruction execution
    localparam int DELAY_100MS = SYS_FREQ_HZ / 10;
    localparam int DELAY_4P1MS = (SYS_FREQ_HZ / 1000) * 41 / 10;
    localparam int DELAY_3MS   = (SYS_FREQ_HZ / 1000) * 3;
    localparam int DELAY_100US = SYS_FREQ_HZ / 10_000;
    localparam int DELAY_53US  = (SYS_FREQ_HZ / 1_000_000) * 53;

    // counter widths, the long one has to hold DELAY_100MS
    localparam int TIMER_BITS     = 22;
    localparam int NYB_COUNT_BITS = 5;

    typedef logic [3:0]            nybble_t;
    typedef logic [7:0]            lcd_byte_t;
    typedef logic [TIMER_BITS-1:0] delay_t;

    // ****************************************************************
    // power-on init table
    // ****************************************************************

    localparam int INIT_STEPS = 10;

    // one init step, wait_ticks counts after the byte sender goes idle
    typedef struct packed {
        lcd_byte_t data;
        logic      nybble_only;
        delay_t    wait_ticks;
    } init_step_t;

    // the first four steps are the 8-bit style reset nybbles, then
    // function set, display off, clear, entry mode and display on twice
    localparam init_step_t INIT_TABLE [INIT_STEPS] = '{
        '{8'h30, 1'b1, delay_t'(DELAY_4P1MS)},
        '{8'h30, 1'b1, delay_t'(DELAY_100US)},
        '{8'h30, 1'b1, delay_t'(DELAY_100US)},
        '{8'h20, 1'b1, delay_t'(DELAY_100US)},
        '{8'h28, 1'b0, delay_t'(0)},
        '{8'h08, 1'b0, delay_t'(0)},
        '{8'h01, 1'b0, delay_t'(0)},
        '{8'h06, 1'b0, delay_t'(0)},
        '{8'h0C, 1'b0, delay_t'(0)},
        '{8'h0C, 1'b0, delay_t'(0)}
    };

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# compiles the LCD controller testbench with Verilator and runs it,
# the exit status is the simulator's own

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module lcd_controller_tb \
    -Mdir obj_dir \
    -f build.f
if [ $? -ne 0 ]; then
    echo "compilation failed"
    exit 1
fi

./obj_dir/Vlcd_controller_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
fi
exit $status

// File: verification/lcd_controller_tb.sv
// ********************************************************************
// testbench for the hd44780 driver, checks the power-on init and a
// table of host bytes against the E pulses seen on the LCD pins
// ********************************************************************
`timescale 1ns/100ps

module lcd_controller_tb;
    import lcd_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_HOST     = 6;

    // expected init steps as byte, upper-nybble-only flag and extra wait
    localparam lcd_byte_t INIT_BYTE [INIT_STEPS] = '{
        8'h30, 8'h30, 8'h30, 8'h20, 8'h28, 8'h08, 8'h01, 8'h06, 8'h0C, 8'h0C
    };
    localparam bit INIT_SINGLE [INIT_STEPS] = '{
        1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0
    };
    localparam int INIT_WAIT [INIT_STEPS] = '{
        DELAY_4P1MS, DELAY_100US, DELAY_100US, DELAY_100US, 0, 0, 0, 0, 0, 0
    };

    logic      CLK_I;
    logic      RST_I;
    logic      i_stb;
    logic      i_rs;
    lcd_byte_t i_data;
    logic      o_busy;
    logic      o_rs;
    logic      o_e;
    nybble_t   o_lcd_data;

    // host table, RS and byte per entry, filled at the start of the run
    logic      host_rs [N_HOST];
    lcd_byte_t host_data [N_HOST];
    int        seed;

    // monitor state, only written on the falling clock edge
    int        cyc;
    int        e_run;
    int        stable_cnt;
    int        first_rise;
    logic      e_prev;
    logic      busy_prev;
    logic      rs_prev;
    nybble_t   nyb_prev;
    logic      fall_rs [$];
    nybble_t   fall_nyb [$];
    int        fall_cyc [$];
    int        idle_cyc [$];

    lcd_controller lcd_controller_i (
        .CLK_I      (CLK_I),
        .RST_I      (RST_I),
        .i_stb      (i_stb),
        .i_rs       (i_rs),
        .i_data     (i_data),
        .o_busy     (o_busy),
        .o_rs       (o_rs),
        .o_e        (o_e),
        .o_lcd_data (o_lcd_data)
    );

    initial begin
        CLK_I = 1'b0;
        forever #(CLK_PERIOD / 2) CLK_I = ~CLK_I;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected)
            else abort_run($sformatf("ERROR %0t: %s is 0x%0h, expected 0x%0h",
                                     $time, name, got, expected));
    endtask

    // clear display and return home take 3 ms, every other byte 53 us
    function automatic int exec_wait(input logic rs, input lcd_byte_t data);
        if (!rs && (data == 8'h01 || data == 8'h02 || data == 8'h03)) begin
            return DELAY_3MS;
        end
        return DELAY_53US;
    endfunction

    // returns on the rising edge after o_busy is seen low
    task automatic wait_idle();
        @(negedge CLK_I);
        while (o_busy) begin
            @(negedge CLK_I);
        end
        @(posedge CLK_I);
    endtask

    // ****************************************************************
    // LCD pin monitor
    // ****************************************************************

    always @(negedge CLK_I) begin
        // an unknown reset before the first edge counts as reset too
        if (RST_I !== 1'b0) begin
            cyc        = 0;
            e_run      = 0;
            stable_cnt = 0;
            first_rise = 0;
            e_prev     = 1'b0;
            busy_prev  = 1'b1;
            rs_prev    = 1'b0;
            nyb_prev   = '0;
        end else begin
            cyc = cyc + 1;
            // stable_cnt is how long RS and data have held their value
            if (o_rs != rs_prev || o_lcd_data != nyb_prev) begin
                stable_cnt = 0;
            end else begin
                stable_cnt = stable_cnt + 1;
            end
            assert (!o_e || stable_cnt >= TICKS_TAS)
                else abort_run("RS or data moved within tAS of E rising or while E was high");
            if (o_e && !e_prev && first_rise == 0) begin
                first_rise = cyc;
            end
            if (o_e) begin
                e_run = e_run + 1;
            end else if (e_prev) begin
                // the LCD latches RS and the nybble on this edge
                check_value("o_e pulse width", e_run, TICKS_PWEH);
                fall_rs.push_back(o_rs);
                fall_nyb.push_back(o_lcd_data);
                fall_cyc.push_back(cyc);
                e_run = 0;
            end
            if (busy_prev && !o_busy) begin
                idle_cyc.push_back(cyc);
            end
            e_prev    = o_e;
            busy_prev = o_busy;
            rs_prev   = o_rs;
            nyb_prev  = o_lcd_data;
        end
    end

    // watchdog, power-up wait plus every table delay and a long
    // execution wait per step, twice over
    initial begin
        int limit;

        limit = DELAY_100MS;
        for (int s = 0; s < INIT_STEPS; s++) begin
            limit = limit + INIT_WAIT[s] + DELAY_3MS;
        end
        repeat (2 * limit) @(posedge CLK_I);
        abort_run("timeout, the DUT did not finish within the watchdog limit");
    end

    // ****************************************************************
    // stimulus and checks
    // ****************************************************************

    initial begin
        logic [31:0] rnd;
        int          nyb_idx;
        int          gap;
        int          need;
        int          base;
        int          init_nybbles;

        RST_I  <= 1'b1;
        i_stb  <= 1'b0;
        i_rs   <= 1'b0;
        i_data <= '0;
        seed = 32'hcdc12884;

        // H, i, DDRAM address 0, clear display, then two random characters
        host_rs   = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
        host_data = '{8'h48, 8'h69, 8'h80, 8'h01, 8'h00, 8'h00};
        rnd = $random(seed);
        host_data[4] = rnd[7:0];
        rnd = $random(seed);
        host_data[5] = rnd[7:0];

        repeat (5) @(posedge CLK_I);
        RST_I <= 1'b0;
        @(negedge CLK_I);
        assert (o_busy) else abort_run("o_busy was low in the first cycle after reset");
        wait_idle();

        // the LCD needs 100 ms after power-up before the first nybble
        assert (first_rise >= DELAY_100MS)
            else abort_run($sformatf("ERROR %0t: first o_e at cycle %0d, expected >= %0d",
                                     $time, first_rise, DELAY_100MS));
        init_nybbles = 0;
        for (int s = 0; s < INIT_STEPS; s++) begin
            init_nybbles = init_nybbles + (INIT_SINGLE[s] ? 1 : 2);
        end
        // busy must not fall before the last init nybble is out
        check_value("init nybble count", fall_nyb.size(), init_nybbles);
        check_value("o_busy falls during init", idle_cyc.size(), 1);

        nyb_idx = 0;
        for (int s = 0; s < INIT_STEPS; s++) begin
            if (s > 0) begin
                gap  = fall_cyc[nyb_idx] - fall_cyc[nyb_idx - 1];
                need = INIT_WAIT[s - 1];
                if (!INIT_SINGLE[s - 1]) begin
                    need = need + exec_wait(1'b0, INIT_BYTE[s - 1]);
                end
                assert (gap >= need)
                    else abort_run($sformatf("ERROR %0t: o_e gap %0d cycles, expected >= %0d",
                                             $time, gap, need));
            end
            check_value("init o_rs", int'(fall_rs[nyb_idx]), 0);
            check_value("init o_lcd_data", int'(fall_nyb[nyb_idx]), int'(INIT_BYTE[s][7:4]));
            nyb_idx = nyb_idx + 1;
            if (!INIT_SINGLE[s]) begin
                check_value("init o_rs", int'(fall_rs[nyb_idx]), 0);
                check_value("init o_lcd_data", int'(fall_nyb[nyb_idx]),
                            int'(INIT_BYTE[s][3:0]));
                nyb_idx = nyb_idx + 1;
            end
        end

        for (int k = 0; k < N_HOST; k++) begin
            base = fall_nyb.size();
            i_stb  <= 1'b1;
            i_rs   <= host_rs[k];
            i_data <= host_data[k];
            @(posedge CLK_I);
            i_stb <= 1'b0;
            @(negedge CLK_I);
            assert (o_busy) else abort_run("o_busy stayed low after an accepted host strobe");
            // a second strobe while busy has to be dropped
            @(posedge CLK_I);
            i_stb  <= 1'b1;
            i_rs   <= !host_rs[k];
            i_data <= ~host_data[k];
            @(posedge CLK_I);
            i_stb <= 1'b0;
            wait_idle();

            check_value("nybbles per host byte", fall_nyb.size() - base, 2);
            check_value("o_busy falls", idle_cyc.size(), k + 2);
            check_value("o_rs upper nybble", int'(fall_rs[base]), int'(host_rs[k]));
            check_value("o_rs lower nybble", int'(fall_rs[base + 1]), int'(host_rs[k]));
            check_value("o_lcd_data byte", int'({fall_nyb[base], fall_nyb[base + 1]}),
                        int'(host_data[k]));
            gap  = idle_cyc[idle_cyc.size() - 1] - fall_cyc[base + 1];
            need = exec_wait(host_rs[k], host_data[k]);
            assert (gap >= need)
                else abort_run($sformatf(
                    "ERROR %0t: o_busy high %0d cycles after E, expected >= %0d",
                    $time, gap, need));
        end

        // nothing may follow the last byte
        repeat (4 * TICKS_TCYCE) @(posedge CLK_I);
        check_value("total nybble count", fall_nyb.size(), init_nybbles + 2 * N_HOST);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: verification/lcd_timing_chk.sv
// ********************************************************************
// LCD pin timing assertions, bound into every nybble sender
// ********************************************************************
`timescale 1ns/100ps

module lcd_timing_chk (
    input logic             CLK_I,
    input logic             RST_I,
    input logic             i_stb,
    input logic             i_busy,
    input logic             i_rs,
    input logic             i_e,
    input lcd_pkg::nybble_t i_lcd_data
);
    import lcd_pkg::*;

    // e_run counts the cycles E has been high, setup_cnt the cycles
    // since RS and data were loaded onto the pins
    int e_run;
    int setup_cnt;

    always_ff @(posedge CLK_I) begin
        if (RST_I) begin
            e_run     <= 0;
            setup_cnt <= TICKS_TCYCE;
        end else begin
            e_run <= i_e ? e_run + 1 : 0;
            if (i_stb && !i_busy) begin
                setup_cnt <= 0;
            end else if (setup_cnt < TICKS_TCYCE) begin
                setup_cnt <= setup_cnt + 1;
            end
        end
    end

    pulse_width_a: assert property (@(posedge CLK_I) disable iff (RST_I)
        $fell(i_e) |-> (e_run == TICKS_PWEH))
        else $error("E pulse lasted %0d cycles", e_run);

    // the LCD samples on the falling edge, so the pins hold while E is high
    hold_a: assert property (@(posedge CLK_I) disable iff (RST_I)
        i_e |-> ($stable(i_rs) && $stable(i_lcd_data)))
        else $error("RS or data changed while E was high");

    setup_a: assert property (@(posedge CLK_I) disable iff (RST_I)
        $rose(i_e) |-> (setup_cnt >= TICKS_TAS))
        else $error("E rose %0d cycles after the pins were loaded", setup_cnt);

endmodule

bind lcd_nybble_sender lcd_timing_chk lcd_timing_chk_i (
    .CLK_I      (CLK_I),
    .RST_I      (RST_I),
    .i_stb      (i_stb),
    .i_busy     (o_busy),
    .i_rs       (o_rs),
    .i_e        (o_e),
    .i_lcd_data (o_lcd_data)
);
